/* hdl/beam_mac.sv */
// ------------------------------------------------
// beam multiply-accumulate
// real part of sample times conjugated code word,
// summed over all antennas, even and odd halves
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module beam_mac #(
    parameter int ANT  = 4,
    parameter int BEAM = 4
) (
    input  logic i_clk,
    input  logic i_reset,
    input  beam_reduce_pkg::iq_t [ANT-1:0] i_ant_even,
    input  beam_reduce_pkg::iq_t [ANT-1:0] i_ant_odd,
    input  logic i_ant_vld,
    input  beam_reduce_pkg::iq_t [BEAM-1:0][ANT-1:0] i_cw_even,
    input  beam_reduce_pkg::iq_t [BEAM-1:0][ANT-1:0] i_cw_odd,
    output beam_reduce_pkg::prod_t [BEAM-1:0] o_beam_sum,
    output logic o_beam_vld
);
    import beam_reduce_pkg::*;

    // re{s * conj(c)} = si*ci + sq*cq
    function automatic prod_t re_conj(input iq_t smp, input iq_t cw);
        logic signed [IQ_W-1:0] s_i;
        logic signed [IQ_W-1:0] s_q;
        logic signed [IQ_W-1:0] c_i;
        logic signed [IQ_W-1:0] c_q;
        s_i = smp[2*IQ_W-1:IQ_W];
        s_q = smp[IQ_W-1:0];
        c_i = cw[2*IQ_W-1:IQ_W];
        c_q = cw[IQ_W-1:0];
        return prod_t'(s_i) * prod_t'(c_i) + prod_t'(s_q) * prod_t'(c_q);
    endfunction

    prod_t      term_even [BEAM][ANT];  // stage 1 products
    prod_t      term_odd  [BEAM][ANT];
    prod_t      beam_add  [BEAM];       // stage 2 adder tree input
    logic [1:0] vld_sr;

    // ------------------------------------------------
    // stage 1: per antenna products
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM; b++) begin
            for (int a = 0; a < ANT; a++) begin
                term_even[b][a] <= re_conj(i_ant_even[a], i_cw_even[b][a]);
                term_odd[b][a]  <= re_conj(i_ant_odd[a], i_cw_odd[b][a]);
            end
        end
    end

    // ------------------------------------------------
    // stage 2: antenna sum per beam
    // ------------------------------------------------
    always_comb begin
        for (int b = 0; b < BEAM; b++) begin
            beam_add[b] = '0;
            for (int a = 0; a < ANT; a++) begin
                beam_add[b] = beam_add[b] + term_even[b][a] + term_odd[b][a];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < BEAM; b++) begin
            o_beam_sum[b] <= beam_add[b];
        end
    end

    // valid follows the two data stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[0], i_ant_vld};
        end
    end

    assign o_beam_vld = vld_sr[1];

endmodule : beam_mac

`default_nettype wire

/* hdl/beam_reduce_pkg.sv */
// ------------------------------------------------
// beam reduce package
// shared sample, product and accumulator widths
// plus the RBG length table
// ------------------------------------------------
`default_nettype none

package beam_reduce_pkg;

    // ------------------------------------------------
    // sample format
    // ------------------------------------------------
    localparam int IQ_W = 16;           // bits per I or Q half

    // I in [31:16], Q in [15:0], both signed
    typedef logic [2*IQ_W-1:0] iq_t;

    // ------------------------------------------------
    // arithmetic widths
    // ------------------------------------------------
    typedef logic signed [39:0] prod_t;      // product / per-element beam sum
    typedef logic signed [47:0] beam_sum_t;  // RBG accumulator

    // ------------------------------------------------
    // control fields
    // ------------------------------------------------
    typedef logic [1:0] rbg_size_t;     // RBG size selector
    typedef logic [7:0] rbg_idx_t;      // group index within a burst
    typedef logic [7:0] blk_idx_t;      // burst counter

    localparam int NUM_BLK = 4;         // code word banks

    // elements per group for each selector value
    localparam int RE_PER_RBG_4  = 48;
    localparam int RE_PER_RBG_8  = 96;
    localparam int RE_PER_RBG_16 = 192;

endpackage : beam_reduce_pkg

`default_nettype wire

/* hdl/codeword_select.sv */
// ------------------------------------------------
// code word bank select
// counts bursts on the falling edge of valid and
// latches the matching code word bank every cycle
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module codeword_select #(
    parameter int ANT  = 4,
    parameter int BEAM = 4
) (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_ant_vld,
    input  beam_reduce_pkg::iq_t [beam_reduce_pkg::NUM_BLK-1:0][BEAM-1:0][ANT-1:0]
        i_code_word_even,
    input  beam_reduce_pkg::iq_t [beam_reduce_pkg::NUM_BLK-1:0][BEAM-1:0][ANT-1:0]
        i_code_word_odd,
    output beam_reduce_pkg::iq_t [BEAM-1:0][ANT-1:0] o_cw_even,
    output beam_reduce_pkg::iq_t [BEAM-1:0][ANT-1:0] o_cw_odd
);
    import beam_reduce_pkg::*;

    localparam blk_idx_t LAST_BLK = blk_idx_t'(NUM_BLK - 1);

    logic     vld_r;
    logic     vld_fall;
    blk_idx_t blk_cnt;

    // ------------------------------------------------
    // burst counter
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            vld_r <= 1'b0;
        end else begin
            vld_r <= i_ant_vld;
        end
    end

    assign vld_fall = vld_r & ~i_ant_vld;   // first low cycle after a burst

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            blk_cnt <= '0;
        end else if (vld_fall && blk_cnt != LAST_BLK) begin
            blk_cnt <= blk_cnt + 1'b1;          // stays on the last bank
        end
    end

    // ------------------------------------------------
    // bank latch
    // ------------------------------------------------
    // reloaded every cycle, settles well inside the burst gap
    always_ff @(posedge i_clk) begin
        o_cw_even <= i_code_word_even[blk_cnt];
        o_cw_odd  <= i_code_word_odd[blk_cnt];
    end

    // counter must never run past the bank table
    a_blk_cnt_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        blk_cnt <= LAST_BLK
    );

endmodule : codeword_select

`default_nettype wire

/* hdl/pdsch_beam_reduce.sv */
// ------------------------------------------------
// PDSCH beam-space dimension reducer, top level
// bank select, beam MAC and RBG accumulation
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pdsch_beam_reduce #(
    parameter int ANT  = 4,
    parameter int BEAM = 4
) (
    input  logic i_clk,
    input  logic i_reset,
    input  beam_reduce_pkg::iq_t [ANT-1:0] i_ant_even,
    input  beam_reduce_pkg::iq_t [ANT-1:0] i_ant_odd,
    input  logic i_ant_vld,
    input  beam_reduce_pkg::iq_t [beam_reduce_pkg::NUM_BLK-1:0][BEAM-1:0][ANT-1:0]
        i_code_word_even,
    input  beam_reduce_pkg::iq_t [beam_reduce_pkg::NUM_BLK-1:0][BEAM-1:0][ANT-1:0]
        i_code_word_odd,
    input  beam_reduce_pkg::rbg_size_t i_rbg_size,
    output beam_reduce_pkg::beam_sum_t [BEAM-1:0] o_rbg_sum,
    output beam_reduce_pkg::rbg_idx_t o_rbg_idx,
    output logic o_rbg_vld
);
    import beam_reduce_pkg::*;

    iq_t   [BEAM-1:0][ANT-1:0] cw_even;     // bank for the current burst
    iq_t   [BEAM-1:0][ANT-1:0] cw_odd;
    prod_t [BEAM-1:0]          beam_sum;    // per element, 2 cycles late
    logic                      beam_vld;

    // ------------------------------------------------
    // code word bank
    // ------------------------------------------------
    codeword_select #(
        .ANT  (ANT),
        .BEAM (BEAM)
    ) u_codeword_select (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_ant_vld        (i_ant_vld),
        .i_code_word_even (i_code_word_even),
        .i_code_word_odd  (i_code_word_odd),
        .o_cw_even        (cw_even),
        .o_cw_odd         (cw_odd)
    );

    // ------------------------------------------------
    // beam MAC
    // ------------------------------------------------
    beam_mac #(
        .ANT  (ANT),
        .BEAM (BEAM)
    ) u_beam_mac (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ant_even (i_ant_even),
        .i_ant_odd  (i_ant_odd),
        .i_ant_vld  (i_ant_vld),
        .i_cw_even  (cw_even),
        .i_cw_odd   (cw_odd),
        .o_beam_sum (beam_sum),
        .o_beam_vld (beam_vld)
    );

    // ------------------------------------------------
    // RBG sums
    // ------------------------------------------------
    rbg_accumulate #(
        .BEAM (BEAM)
    ) u_rbg_accumulate (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_beam_sum (beam_sum),
        .i_beam_vld (beam_vld),
        .i_rbg_size (i_rbg_size),
        .o_rbg_sum  (o_rbg_sum),
        .o_rbg_idx  (o_rbg_idx),
        .o_rbg_vld  (o_rbg_vld)
    );

endmodule : pdsch_beam_reduce

`default_nettype wire

/* hdl/rbg_accumulate.sv */
// ------------------------------------------------
// RBG accumulator
// adds per-element beam sums over one resource
// block group, emits one sum per beam with its
// index, flushes a partial group at burst end
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module rbg_accumulate #(
    parameter int BEAM = 4
) (
    input  logic i_clk,
    input  logic i_reset,
    input  beam_reduce_pkg::prod_t [BEAM-1:0] i_beam_sum,
    input  logic i_beam_vld,
    input  beam_reduce_pkg::rbg_size_t i_rbg_size,
    output beam_reduce_pkg::beam_sum_t [BEAM-1:0] o_rbg_sum,
    output beam_reduce_pkg::rbg_idx_t o_rbg_idx,
    output logic o_rbg_vld
);
    import beam_reduce_pkg::*;

    localparam int CNT_W = 8;           // holds up to 191

    typedef enum logic [0:0] {
        IDLE,
        ACCUM
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] re_cnt;           // elements already in acc
    logic [CNT_W-1:0] last_cnt;
    logic             last_re;
    logic             burst_end;
    rbg_idx_t         rbg_idx;
    beam_sum_t        acc      [BEAM];
    beam_sum_t        acc_next [BEAM];

    // ------------------------------------------------
    // group length
    // ------------------------------------------------
    always_comb begin
        case (i_rbg_size)
            2'd1:    last_cnt = CNT_W'(RE_PER_RBG_8 - 1);
            2'd2:    last_cnt = CNT_W'(RE_PER_RBG_16 - 1);
            default: last_cnt = CNT_W'(RE_PER_RBG_4 - 1);  // 0 and 3
        endcase
    end

    assign last_re   = i_beam_vld && (re_cnt == last_cnt);
    assign burst_end = !i_beam_vld && (state == ACCUM);

    // first element of a group starts from zero
    always_comb begin
        for (int b = 0; b < BEAM; b++) begin
            acc_next[b] = ((re_cnt == '0) ? beam_sum_t'(0) : acc[b])
                        + beam_sum_t'($signed(i_beam_sum[b]));
        end
    end

    // ------------------------------------------------
    // control
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= IDLE;
            re_cnt    <= '0;
            rbg_idx   <= '0;
            o_rbg_vld <= 1'b0;
        end else begin
            o_rbg_vld <= 1'b0;
            if (i_beam_vld) begin
                state <= ACCUM;
                if (last_re) begin
                    re_cnt    <= '0;
                    rbg_idx   <= rbg_idx + 1'b1;
                    o_rbg_vld <= 1'b1;
                end else begin
                    re_cnt <= re_cnt + 1'b1;
                end
            end else if (burst_end) begin
                state     <= IDLE;
                re_cnt    <= '0;
                rbg_idx   <= '0;            // next burst restarts at group 0
                o_rbg_vld <= (re_cnt != '0); // partial group pending
            end
        end
    end

    // ------------------------------------------------
    // datapath
    // ------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_beam_vld) begin
            for (int b = 0; b < BEAM; b++) begin
                acc[b] <= acc_next[b];
            end
        end
        if (last_re) begin
            for (int b = 0; b < BEAM; b++) begin
                o_rbg_sum[b] <= acc_next[b];
            end
            o_rbg_idx <= rbg_idx;
        end else if (burst_end) begin
            for (int b = 0; b < BEAM; b++) begin
                o_rbg_sum[b] <= acc[b];     // flush what is left
            end
            o_rbg_idx <= rbg_idx;
        end
    end

    // a full group is never followed by a flush on the next cycle
    a_vld_single: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_rbg_vld |=> !o_rbg_vld
    );

    a_cnt_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        re_cnt < CNT_W'(RE_PER_RBG_16)
    );

endmodule : rbg_accumulate

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the beam reducer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -Wno-fatal \
    --top-module tb_pdsch_beam_reduce \
    --Mdir obj_dir \
    -f src.f

./obj_dir/Vtb_pdsch_beam_reduce > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Testbench passed" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

/* src.f */
+incdir+tests
hdl/beam_reduce_pkg.sv
hdl/codeword_select.sv
hdl/beam_mac.sv
hdl/rbg_accumulate.sv
hdl/pdsch_beam_reduce.sv
tests/tb_pdsch_beam_reduce.sv

/* tests/beam_reduce_model.svh */
// ------------------------------------------------
// beam reduce reference model
// LFSR step, conjugate product rule, group length
// ------------------------------------------------
`ifndef BEAM_REDUCE_MODEL_SVH
`define BEAM_REDUCE_MODEL_SVH

// galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

// re{s * conj(c)} with I in the upper half
function automatic longint real_conj(input iq_t s, input iq_t c);
    longint s_re;
    longint s_im;
    longint c_re;
    longint c_im;
    s_re = longint'($signed(s[31:16]));
    s_im = longint'($signed(s[15:0]));
    c_re = longint'($signed(c[31:16]));
    c_im = longint'($signed(c[15:0]));
    return (s_re * c_re) + (s_im * c_im);
endfunction

// one beam, one element, even plus odd over all antennas
function automatic longint element_beam_sum(input iq_t [ANT-1:0] ev,
                                            input iq_t [ANT-1:0] od,
                                            input iq_t [ANT-1:0] cw_ev,
                                            input iq_t [ANT-1:0] cw_od);
    longint total;
    total = 0;
    for (int a = 0; a < ANT; a++) begin
        total += real_conj(ev[a], cw_ev[a]);
        total += real_conj(od[a], cw_od[a]);
    end
    return total;
endfunction

// selector to elements per group, 3 falls back to 48
function automatic int rbg_length(input rbg_size_t sel);
    case (sel)
        2'd1:    return RE_PER_RBG_8;
        2'd2:    return RE_PER_RBG_16;
        default: return RE_PER_RBG_4;
    endcase
endfunction

`endif

/* tests/tb_pdsch_beam_reduce.sv */
// ------------------------------------------------
// testbench for the PDSCH beam reducer
// random bursts checked against a reference model
// ------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_pdsch_beam_reduce;
    import beam_reduce_pkg::*;

    localparam int ANT       = 4;
    localparam int BEAM      = 4;
    localparam int NUM_BURST = 8;   // more than NUM_BLK, last bank gets reused

    typedef beam_sum_t [BEAM-1:0] rbg_vec_t;

    logic                                   i_clk;
    logic                                   i_reset;
    iq_t [ANT-1:0]                          i_ant_even;
    iq_t [ANT-1:0]                          i_ant_odd;
    logic                                   i_ant_vld;
    iq_t [NUM_BLK-1:0][BEAM-1:0][ANT-1:0]   i_code_word_even;
    iq_t [NUM_BLK-1:0][BEAM-1:0][ANT-1:0]   i_code_word_odd;
    rbg_size_t                              i_rbg_size;
    beam_sum_t [BEAM-1:0]                   o_rbg_sum;
    rbg_idx_t                               o_rbg_idx;
    logic                                   o_rbg_vld;

    logic [31:0] lfsr_state = 32'h44ad;
    rbg_vec_t    exp_sum_q [$];
    rbg_idx_t    exp_idx_q [$];
    int          sum_errors   = 0;
    int          idx_errors   = 0;
    int          other_errors = 0;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;
    int          burst_len  [NUM_BURST];
    int          burst_gap  [NUM_BURST];
    rbg_size_t   burst_size [NUM_BURST];

    `include "beam_reduce_model.svh"

    pdsch_beam_reduce #(
        .ANT  (ANT),
        .BEAM (BEAM)
    ) UUT (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_ant_even       (i_ant_even),
        .i_ant_odd        (i_ant_odd),
        .i_ant_vld        (i_ant_vld),
        .i_code_word_even (i_code_word_even),
        .i_code_word_odd  (i_code_word_odd),
        .i_rbg_size       (i_rbg_size),
        .o_rbg_sum        (o_rbg_sum),
        .o_rbg_idx        (o_rbg_idx),
        .o_rbg_vld        (o_rbg_vld)
    );

    // one LFSR step per bit, msb first
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_sum(input string name, input beam_sum_t got, input beam_sum_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            sum_errors++;
        end
    endtask

    task automatic check_idx(input string name, input rbg_idx_t got, input rbg_idx_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            idx_errors++;
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // ------------------------------------------------
    // watchdog
    // ------------------------------------------------
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------
    // output monitor
    // ------------------------------------------------
    always @(posedge i_clk) begin
        rbg_vec_t exp_vec;
        rbg_idx_t exp_idx;
        if (!i_reset && o_rbg_vld) begin
            if (exp_idx_q.size() == 0) begin
                $display("o_rbg_vld pulsed with no RBG result pending");
                other_errors++;
            end else begin
                exp_vec = exp_sum_q.pop_front();
                exp_idx = exp_idx_q.pop_front();
                for (int b = 0; b < BEAM; b++) begin
                    check_sum($sformatf("o_rbg_sum[%0d]", b), o_rbg_sum[b], exp_vec[b]);
                end
                check_idx("o_rbg_idx", o_rbg_idx, exp_idx);
            end
        end
    end

    // ------------------------------------------------
    // stimulus and model
    // ------------------------------------------------
    initial begin : stimulus
        iq_t [ANT-1:0] ev;
        iq_t [ANT-1:0] od;
        longint        acc [BEAM];
        rbg_vec_t      res;
        rbg_idx_t      idx;
        int            bank;
        int            glen;
        int            cnt;
        int            total;

        i_reset    = 1'b1;
        i_ant_vld  = 1'b0;
        i_ant_even = '0;
        i_ant_odd  = '0;
        i_rbg_size = '0;

        total = 0;
        for (int i = 0; i < NUM_BURST; i++) begin
            burst_len[i]  = 20 + int'(draw_bits(9));    // 20 to 531 elements
            burst_gap[i]  = 3 + int'(draw_bits(2));     // 3 to 6 idle cycles
            burst_size[i] = rbg_size_t'(draw_bits(2));
            total += burst_len[i] + burst_gap[i];
        end
        cycle_limit = total + 50;

        for (int k = 0; k < NUM_BLK; k++) begin
            for (int b = 0; b < BEAM; b++) begin
                for (int a = 0; a < ANT; a++) begin
                    i_code_word_even[k][b][a] = draw_bits(32);
                    i_code_word_odd[k][b][a]  = draw_bits(32);
                end
            end
        end

        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        repeat (4) @(posedge i_clk);     // quiet, no pulse allowed here

        for (int i = 0; i < NUM_BURST; i++) begin
            bank = (i < NUM_BLK) ? i : NUM_BLK - 1;
            glen = rbg_length(burst_size[i]);
            cnt  = 0;
            idx  = '0;
            for (int b = 0; b < BEAM; b++) begin
                acc[b] = 0;
            end
            for (int e = 0; e < burst_len[i]; e++) begin
                @(posedge i_clk);
                for (int a = 0; a < ANT; a++) begin
                    ev[a] = draw_bits(32);
                    od[a] = draw_bits(32);
                end
                i_ant_even <= ev;
                i_ant_odd  <= od;
                i_ant_vld  <= 1'b1;
                i_rbg_size <= burst_size[i];
                for (int b = 0; b < BEAM; b++) begin
                    acc[b] += element_beam_sum(ev, od, i_code_word_even[bank][b],
                                               i_code_word_odd[bank][b]);
                end
                cnt++;
                if (cnt == glen || e == burst_len[i] - 1) begin  // full group or burst tail
                    for (int b = 0; b < BEAM; b++) begin
                        res[b] = beam_sum_t'(acc[b]);
                        acc[b] = 0;
                    end
                    exp_sum_q.push_back(res);
                    exp_idx_q.push_back(idx);
                    idx = idx + 8'd1;
                    cnt = 0;
                end
            end
            for (int g = 0; g < burst_gap[i]; g++) begin
                @(posedge i_clk);
                i_ant_vld <= 1'b0;
            end
        end

        repeat (10) @(posedge i_clk);    // last flush, then nothing more
        if (exp_idx_q.size() != 0) begin
            $display("%0d expected RBG results were never produced", exp_idx_q.size());
            other_errors++;
        end
        $display("errors: sum %0d, index %0d, other %0d", sum_errors, idx_errors,
                 other_errors);
        if (sum_errors + idx_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_pdsch_beam_reduce

`default_nettype wire
